/* Bender.yml */
package:
  name: uop_expander

sources:
  # Packages first, the modules depend on them
  - armIsaPkg.sv
  - uopPkg.sv
  # Datapath and control
  - regListTracker.sv
  - blockAddrCalc.sv
  - uopEncoder.sv
  - uopSequencer.sv
  # Top level
  - uopExpander.sv
  # Verification only
  - target: test
    files:
      - uopExpander_properties.sv
      - tbUopExpander.sv

/* armIsaPkg.sv */
`default_nettype none

package armIsaPkg;

	parameter int InstrWidth = 32;                // Instruction and micro-op width

	typedef logic [InstrWidth-1:0] instrT;         // One instruction word
	typedef logic [3:0]            regIdxT;        // Register number
	typedef logic [15:0]           regListT;       // LDM/STM register list field

	parameter int CondMsb      = 31;               // Condition field
	parameter int CondLsb      = 28;
	parameter int RnMsb        = 19;               // Base or first operand register
	parameter int RdMsb        = 15;               // Destination register
	parameter int LoadBit      = 20;               // L bit of transfers
	parameter int WriteBackBit = 21;               // W bit
	parameter int UserBankBit  = 22;               // S bit of LDM/STM
	parameter int UpBit        = 23;               // U bit
	parameter int PreBit       = 24;               // P bit
	parameter int LinkBit      = 24;               // L bit of B/BL

	parameter logic [2:0] ClassDpReg = 3'b000;     // Data processing with register operand
	parameter logic [2:0] ClassDpImm = 3'b001;     // Data processing with immediate
	parameter logic [2:0] ClassLsImm = 3'b010;     // Single LDR/STR with immediate offset
	parameter logic [2:0] ClassBlock = 3'b100;     // LDM/STM
	parameter logic [2:0] ClassBranch = 3'b101;    // B and BL

	parameter logic [3:0] OpcAdd = 4'b0100;
	parameter logic [3:0] OpcSub = 4'b0010;
	parameter logic [3:0] OpcMov = 4'b1101;

	parameter regIdxT RzIdx = 4'd15;               // Hidden Rz when the Rz control selects it
	parameter regIdxT PcIdx = 4'd15;
	parameter regIdxT LrIdx = 4'd14;

	parameter logic [11:0] PcOffset = 12'd4;       // One word, also PC - 4

endpackage

`default_nettype wire

/* blockAddrCalc.sv */
`timescale 1ns/100ps
`default_nettype none

module blockAddrCalc #(
	parameter int RegCount = 16
) (
	input  armIsaPkg::instrT              instr,
	input  logic [$clog2(RegCount+1)-1:0] total,        // Registers in the list
	output logic [11:0]                   startOffset,  // Distance from Rn to the lowest word
	output logic                          addUp         // Add rather than subtract
);
	import armIsaPkg::*;

	logic [11:0] listBytes;

	assign listBytes = 12'(total) << 2;                 // 4 bytes per register

	always_comb begin
		case ({instr[PreBit], instr[UpBit]})
			2'b00: begin                                // Decrement after
				startOffset = listBytes - PcOffset;
				addUp = 1'b0;
			end
			2'b01: begin                                // Increment after
				startOffset = 12'd0;
				addUp = 1'b1;
			end
			2'b10: begin                                // Decrement before
				startOffset = listBytes;
				addUp = 1'b0;
			end
			default: begin                              // Increment before
				startOffset = PcOffset;
				addUp = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* regListTracker.sv */
`timescale 1ns/100ps
`default_nettype none

module regListTracker #(
	parameter int RegCount = 16
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          hold,
	input  logic                          listLoad,
	input  logic                          listStep,
	input  armIsaPkg::instrT              instr,
	output armIsaPkg::regIdxT             nextReg,     // Lowest register still listed
	output logic [$clog2(RegCount+1)-1:0] remaining,   // Set bits of the live list
	output logic [$clog2(RegCount+1)-1:0] total        // Set bits of the instruction list
);
	import armIsaPkg::*;

	localparam int CountWidth = $clog2(RegCount+1);

	regListT             instrList;
	logic [RegCount-1:0] liveList;

	assign instrList = instr[15:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			liveList <= '0;
		end else if (!hold) begin
			if (listLoad) begin
				liveList <= instrList[RegCount-1:0];
			end else if (listStep) begin
				liveList <= liveList & (liveList - 1'b1);  // Clear lowest set bit
			end
		end
	end

	assign remaining = CountWidth'($countones(liveList));
	assign total = CountWidth'($countones(instrList[RegCount-1:0]));

	// Scan down so the lowest set bit wins
	always_comb begin
		nextReg = '0;
		for (int i = RegCount - 1; i >= 0; i--) begin
			if (liveList[i]) begin
				nextReg = regIdxT'(i);
			end
		end
	end

endmodule

`default_nettype wire

/* tbUopExpander.sv */
`timescale 1ns/100ps
`default_nettype none

module tbUopExpander;
	import armIsaPkg::*;
	import uopPkg::*;

	localparam int RegCount = 16;
	localparam instrT PlainAdd = 32'hE082_1003;      // ADD r1, r2, r3 with immediate shift
	localparam instrT ShiftedAdd = 32'hE082_1413;    // ADD r1, r2, r3 LSL r4

	logic        clk;
	logic        reset;
	instrT       instr;
	logic        hold;
	instrT       uop;
	logic        instrSelect;
	logic        flagHold;
	logic        uopStall;
	logic        forwardXfer;
	logic        rsrSecondPass;
	rzCtrlT      rzCtrl;
	int          wordErrors = 0;
	int          bitErrors = 0;
	int          rzErrors = 0;
	int          timeouts = 0;

	uopExpander #(.RegCount(RegCount)) uut (.*);

	always #4 clk = ~clk;                             // 8 ns period

	// Drive 1 ns after the edge, sample at the falling edge
	task automatic driveCycle(input instrT ins, input logic holdLevel);
		@(posedge clk);
		#1;
		instr = ins;
		hold = holdLevel;
		@(negedge clk);
	endtask

	task automatic checkWord(input string name, input instrT actual, input instrT expected);
		if (actual !== expected) begin
			wordErrors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			bitErrors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic checkRz(input string name, input rzCtrlT actual, input rzCtrlT expected);
		if (actual !== expected) begin
			rzErrors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic checkStrobes(input logic sel, input logic stall, input logic flags,
		input logic fwd, input logic second, input rzCtrlT rz);
		checkBit("instrSelect", instrSelect, sel);
		checkBit("uopStall", uopStall, stall);
		checkBit("flagHold", flagHold, flags);
		checkBit("forwardXfer", forwardXfer, fwd);
		checkBit("rsrSecondPass", rsrSecondPass, second);
		checkRz("rzCtrl", rzCtrl, rz);
	endtask

	task automatic waitStallLow(input int limit);
		int cycles;
		cycles = 0;
		while (uopStall !== 1'b0 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (uopStall !== 1'b0) begin
			timeouts++;
			$display("Timed out after %0d cycles waiting for uopStall to fall", limit);
		end
	endtask

	// Rz selects by field: initial mux, write port, read port 2, read port 1
	function automatic rzCtrlT rzSelect(input logic initMux, input logic wr, input logic rd2,
		input logic rd1);
		rzCtrlT c;
		c.rd1InitMux = initMux;
		c.wrRz = wr;
		c.rd2Rz = rd2;
		c.rd1Rz = rd1;
		return c;
	endfunction

	function automatic int bitCount(input regListT list);
		int n;
		n = 0;
		for (int i = 0; i < 16; i++) begin
			n += list[i];
		end
		return n;
	endfunction

	function automatic instrT blockInstr(input logic p, input logic u, input logic w,
		input logic l, input regIdxT rn, input regListT list);
		return {4'hE, 3'b100, p, u, 1'b0, w, l, rn, list};   // LDM/STM, S clear
	endfunction

	function automatic instrT movToRz(input instrT ins);
		instrT w;
		w = '0;
		w[31:28] = ins[31:28];
		w[24:21] = OpcMov;                                // Register operand form, S clear
		w[15:12] = 4'hF;                                  // Rz
		w[11:0] = ins[11:0];                              // Shift by register kept
		return w;
	endfunction

	function automatic instrT operateOnRz(input instrT ins);
		return {ins[31:12], 8'h00, 4'hF};                 // Rm becomes Rz, no shift
	endfunction

	function automatic instrT linkWord(input instrT ins);
		return {ins[31:28], 3'b001, OpcSub, 1'b0, 4'd15, 4'd14, 12'd4};
	endfunction

	function automatic instrT branchWord(input instrT ins);
		instrT w;
		w = ins;
		w[24] = 1'b0;                                     // Link bit off
		return w;
	endfunction

	function automatic instrT startAddrWord(input instrT ins);
		int          n;
		logic [11:0] off;
		logic        up;
		n = bitCount(ins[15:0]);
		case ({ins[24], ins[23]})
			2'b00: begin                                  // Decrement after
				off = 12'(4 * n - 4);
				up = 1'b0;
			end
			2'b01: begin                                  // Increment after
				off = 12'd0;
				up = 1'b1;
			end
			2'b10: begin                                  // Decrement before
				off = 12'(4 * n);
				up = 1'b0;
			end
			default: begin                                // Increment before
				off = 12'd4;
				up = 1'b1;
			end
		endcase
		return {ins[31:28], 3'b001, up ? OpcAdd : OpcSub, 1'b0, ins[19:16], 4'hF, off};
	endfunction

	function automatic instrT transferWord(input instrT ins, input regIdxT r);
		return {ins[31:28], 3'b010, 4'b0100, ins[20], 4'hF, r, 12'd4};  // Post-indexed, up
	endfunction

	function automatic instrT baseUpdateWord(input instrT ins);
		return {ins[31:28], 3'b001, ins[23] ? OpcAdd : OpcSub, 1'b0,
			ins[19:16], ins[19:16], 4'hF, 8'(bitCount(ins[15:0]))};
	endfunction

	task automatic passThroughTest();
		driveCycle(PlainAdd, 1'b0);
		checkWord("uop", uop, PlainAdd);
		checkStrobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	task automatic rsrTest();
		instrT ins;
		ins = ShiftedAdd;
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, movToRz(ins));
		checkStrobes(1'b1, 1'b1, 1'b1, 1'b0, 1'b0,
			rzSelect(1'b1, 1'b1, 1'b0, 1'b0));            // Rs via initial mux, write Rz
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, operateOnRz(ins));
		checkStrobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b1,
			rzSelect(1'b0, 1'b0, 1'b1, 1'b0));            // Rz in the Rm slot
		waitStallLow(4);
	endtask

	task automatic blTest();
		instrT ins;
		ins = 32'hEB00_0010;
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, linkWord(ins));
		checkStrobes(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b0));
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, branchWord(ins));
		checkStrobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b0));
		waitStallLow(4);
	endtask

	task automatic blockTest(input logic p, input logic u, input logic w, input logic l);
		regListT list;
		instrT   ins;
		int      n;
		int      seen;
		list = regListT'($urandom);
		if (list == '0) begin
			list = 16'h0001;                              // Keep the list non-empty
		end
		ins = blockInstr(p, u, w, l, regIdxT'($urandom % 15), list);
		n = bitCount(list);
		seen = 0;
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, startAddrWord(ins));
		checkStrobes(1'b1, 1'b1, 1'b1, 1'b0, 1'b0,
			rzSelect(1'b0, 1'b1, 1'b0, 1'b0));            // Start address to Rz
		for (int r = 0; r < 16; r++) begin
			if (list[r]) begin
				seen++;
				driveCycle(ins, 1'b0);
				checkWord("uop", uop, transferWord(ins, regIdxT'(r)));
				checkStrobes(1'b1, (seen < n) || w, 1'b1, 1'b1, 1'b0,
					rzSelect(1'b0, 1'b0, 1'b0, 1'b1));    // Rz is the base
			end
		end
		if (w) begin
			driveCycle(ins, 1'b0);
			checkWord("uop", uop, baseUpdateWord(ins));
			checkStrobes(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b0));
		end
		waitStallLow(4);
	endtask

	task automatic blockModes(input logic w);
		logic [1:0] mode;
		for (int m = 0; m < 4; m++) begin
			mode = 2'(m);
			blockTest(mode[1], mode[0], w, mode[0] ^ w);  // Mix loads and stores
		end
	endtask

	task automatic holdTest();
		instrT ins;
		instrT heldUop;
		ins = blockInstr(1'b1, 1'b1, 1'b1, 1'b1, 4'd3, 16'h00A6);  // r1, r2, r5, r7
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, startAddrWord(ins));
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, transferWord(ins, 4'd1));
		driveCycle(ins, 1'b1);                            // Next edge is held
		heldUop = uop;
		checkWord("uop", uop, transferWord(ins, 4'd2));
		repeat (3) begin
			driveCycle(ins, 1'b1);
			checkWord("uop", uop, heldUop);
			checkStrobes(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b1));
		end
		driveCycle(ins, 1'b0);                            // Last held edge just passed
		checkWord("uop", uop, heldUop);
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, transferWord(ins, 4'd5));
		checkStrobes(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b1));
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, transferWord(ins, 4'd7));
		checkStrobes(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b1));
		driveCycle(ins, 1'b0);
		checkWord("uop", uop, baseUpdateWord(ins));
		checkStrobes(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, rzSelect(1'b0, 1'b0, 1'b0, 1'b0));
		waitStallLow(4);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		hold = 1'b0;
		instr = ShiftedAdd;                               // Multi-pass word while in reset
		void'($urandom(32'h2a29_0e4a));
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		instr = PlainAdd;
		passThroughTest();
		rsrTest();
		blTest();
		blockModes(1'b0);
		blockModes(1'b1);
		holdTest();
		driveCycle(PlainAdd, 1'b0);
		$display("Errors: %0d word, %0d strobe, %0d rzCtrl, %0d timeout, %0d assertion",
			wordErrors, bitErrors, rzErrors, timeouts, uut.props.failCount);
		if (wordErrors + bitErrors + rzErrors + timeouts + uut.props.failCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* uopEncoder.sv */
`timescale 1ns/100ps
`default_nettype none

module uopEncoder (
	input  armIsaPkg::instrT  instr,
	input  uopPkg::uopKindT   kind,
	input  armIsaPkg::regIdxT nextReg,        // Data register of the current transfer
	input  logic [11:0]       startOffset,
	input  logic              addUp,
	output armIsaPkg::instrT  uop
);
	import armIsaPkg::*;
	import uopPkg::*;

	logic [3:0] cond;
	regIdxT     rn;
	regListT    instrList;
	logic [7:0] listCount;
	logic [3:0] addrOpc;
	logic [3:0] wbOpc;

	assign cond = instr[CondMsb:CondLsb];
	assign rn = instr[RnMsb -: 4];
	assign instrList = instr[15:0];
	assign listCount = 8'($countones(instrList));
	assign addrOpc = addUp ? OpcAdd : OpcSub;
	assign wbOpc = instr[UpBit] ? OpcAdd : OpcSub;

	always_comb begin
		uop = instr;
		case (kind)
			kindRsrMove: begin
				uop = {cond, ClassDpReg, OpcMov, 1'b0,     // MOV, S clear
					4'b0000, RzIdx,                        // Rn unused, Rz destination
					instr[11:0]};                          // Original shift by register
			end
			kindRsrOperate: begin
				uop = {instr[InstrWidth-1:RdMsb-3],        // Opcode, Rn and Rd kept
					8'h00, RzIdx};                         // Rz with no shift
			end
			kindBlLink: begin
				uop = {cond, ClassDpImm, OpcSub, 1'b0,
					PcIdx, LrIdx, PcOffset};               // LR = PC - 4
			end
			kindBlBranch: begin
				uop = instr;
				uop[LinkBit] = 1'b0;                       // Plain B
			end
			kindBlockAddr: begin
				uop = {cond, ClassDpImm, addrOpc, 1'b0,
					rn, RzIdx,                             // Rz = Rn +/- start
					startOffset};                          // Small enough for rotate 0
			end
			kindBlockXfer: begin
				uop = {cond, ClassLsImm,
					1'b0, 1'b1, 1'b0, 1'b0,                // Post-indexed, up, word
					instr[LoadBit],
					RzIdx, nextReg,                        // Base Rz
					PcOffset};                             // Step one word
			end
			kindBlockWriteback: begin
				uop = {cond, ClassDpImm, wbOpc, 1'b0,
					rn, rn,
					4'hF, listCount};                      // N ror 30 gives 4N
			end
			default: begin
				uop = instr;                               // Pass through
			end
		endcase
	end

endmodule

`default_nettype wire

/* uopExpander.f */
armIsaPkg.sv
uopPkg.sv
regListTracker.sv
blockAddrCalc.sv
uopEncoder.sv
uopSequencer.sv
uopExpander.sv
uopExpander_properties.sv
tbUopExpander.sv

/* uopExpander.sv */
`timescale 1ns/100ps
`default_nettype none

module uopExpander #(
	parameter int RegCount = 16                    // Register list length
) (
	input  logic             clk,
	input  logic             reset,
	input  armIsaPkg::instrT instr,                // Decode-stage instruction
	input  logic             hold,                 // Pipeline stall from the core
	output armIsaPkg::instrT uop,
	output logic             instrSelect,          // Pick uop over instr
	output logic             flagHold,
	output logic             uopStall,             // Stall fetch
	output logic             forwardXfer,
	output logic             rsrSecondPass,
	output uopPkg::rzCtrlT   rzCtrl
);
	import armIsaPkg::*;
	import uopPkg::*;

	uopKindT                       kind;
	logic                          listLoad;
	logic                          listStep;
	logic [$clog2(RegCount+1)-1:0] remaining;
	logic [$clog2(RegCount+1)-1:0] total;
	regIdxT                        nextReg;
	logic [11:0]                   startOffset;
	logic                          addUp;

	uopSequencer #(.RegCount(RegCount)) sequencer (
		.clk, .reset, .hold, .instr, .remaining,
		.kind, .listLoad, .listStep, .instrSelect, .flagHold,
		.uopStall, .forwardXfer, .rsrSecondPass, .rzCtrl
	);

	regListTracker #(.RegCount(RegCount)) tracker (
		.clk, .reset, .hold, .listLoad, .listStep, .instr,
		.nextReg, .remaining, .total
	);

	blockAddrCalc #(.RegCount(RegCount)) addrCalc (
		.instr, .total, .startOffset, .addUp
	);

	uopEncoder encoder (
		.instr, .kind, .nextReg, .startOffset, .addUp, .uop
	);

endmodule

`default_nettype wire

/* uopExpander_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module uopExpanderProperties (
	input logic             clk,
	input logic             reset,
	input armIsaPkg::instrT instr,
	input logic             hold,
	input armIsaPkg::instrT uop,
	input logic             instrSelect,
	input logic             flagHold,
	input logic             uopStall,
	input logic             forwardXfer,
	input logic             rsrSecondPass,
	input uopPkg::rzCtrlT   rzCtrl
);

	int failCount = 0;                             // Failed assertion count

	// Second cycle of reset onward, state is idle by then
	assert property (@(posedge clk) reset && $past(reset) |-> !uopStall)
		else begin
			failCount++;
			$error("uopStall high during reset");
		end

	// A held edge freezes the state, so outputs follow only instr
	assert property (@(posedge clk) disable iff (reset)
		$past(hold) && !$past(reset) && $stable(instr)
		|-> $stable(uop) && $stable(instrSelect) && $stable(flagHold)
			&& $stable(uopStall) && $stable(forwardXfer)
			&& $stable(rsrSecondPass) && $stable(rzCtrl))
		else begin
			failCount++;
			$error("Outputs changed across a held edge");
		end

	assert property (@(posedge clk) disable iff (reset) rsrSecondPass |-> instrSelect)
		else begin
			failCount++;
			$error("rsrSecondPass without instrSelect");
		end

endmodule

bind uopExpander uopExpanderProperties props (.*);

`default_nettype wire

/* uopPkg.sv */
`default_nettype none

package uopPkg;

	typedef enum logic [2:0] {
		stIdle,                                    // Classifies the decode instruction
		stRsrSecond,                               // Operation on Rz
		stBlSecond,                                // Plain branch after the link
		stBlockXfer,                               // One word per listed register
		stBlockWriteback                           // Base update
	} seqStateT;

	typedef enum logic [2:0] {
		kindPassThrough,
		kindRsrMove,
		kindRsrOperate,
		kindBlLink,
		kindBlBranch,
		kindBlockAddr,
		kindBlockXfer,
		kindBlockWriteback
	} uopKindT;

	typedef struct packed {
		logic rd1InitMux;                          // Initial mux in front of read port 1
		logic wrRz;                                // Write port targets Rz
		logic rd2Rz;                               // Read port 2 reads Rz
		logic rd1Rz;                               // Read port 1 reads Rz
	} rzCtrlT;

	parameter rzCtrlT RzOff        = 4'b0000;
	parameter rzCtrlT RzRsrMove    = 4'b1100;      // Shifted operand lands in Rz
	parameter rzCtrlT RzRsrOperate = 4'b0010;      // Rz replaces Rm
	parameter rzCtrlT RzBlockAddr  = 4'b0100;      // Start address lands in Rz
	parameter rzCtrlT RzBlockXfer  = 4'b0001;      // Rz is the transfer base

endpackage

`default_nettype wire

/* uopSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module uopSequencer #(
	parameter int RegCount = 16
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          hold,
	input  armIsaPkg::instrT              instr,
	input  logic [$clog2(RegCount+1)-1:0] remaining,     // Registers still to transfer
	output uopPkg::uopKindT               kind,
	output logic                          listLoad,      // Capture the list on the next edge
	output logic                          listStep,      // Drop the lowest register
	output logic                          instrSelect,
	output logic                          flagHold,
	output logic                          uopStall,
	output logic                          forwardXfer,
	output logic                          rsrSecondPass,
	output uopPkg::rzCtrlT                rzCtrl
);
	import armIsaPkg::*;
	import uopPkg::*;

	seqStateT state;
	seqStateT nextState;
	logic     isRsr;
	logic     isBl;
	logic     isBlock;
	logic     lastXfer;

	// Register-shifted register operand, BX shares the bit pattern
	assign isRsr = (instr[27:25] == ClassDpReg) && !instr[7] && instr[4]
		&& (instr[27:8] != 20'h12FFF);
	assign isBl = (instr[27:24] == {ClassBranch, 1'b1});
	// Empty lists and user-bank forms go through untouched
	assign isBlock = (instr[27:25] == ClassBlock) && !instr[UserBankBit]
		&& (|instr[RegCount-1:0]);
	assign lastXfer = (remaining == 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
		end else if (!hold) begin                      // Frozen while the core stalls
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		kind = kindPassThrough;
		listLoad = 1'b0;
		listStep = 1'b0;
		instrSelect = 1'b1;                            // Every state but a plain idle uses uop
		flagHold = 1'b0;
		uopStall = 1'b0;
		forwardXfer = 1'b0;
		rsrSecondPass = 1'b0;
		rzCtrl = RzOff;
		case (state)
			stIdle: begin
				if (reset) begin
					instrSelect = 1'b0;                    // No sequence starts in reset
				end else if (isRsr) begin
					kind = kindRsrMove;                    // Rz = shifted operand
					flagHold = 1'b1;                       // Flags belong to the real op
					uopStall = 1'b1;
					rzCtrl = RzRsrMove;
					nextState = stRsrSecond;
				end else if (isBl) begin
					kind = kindBlLink;                     // LR = PC - 4
					uopStall = 1'b1;
					nextState = stBlSecond;
				end else if (isBlock) begin
					kind = kindBlockAddr;                  // Rz = start address
					flagHold = 1'b1;
					uopStall = 1'b1;
					listLoad = 1'b1;
					rzCtrl = RzBlockAddr;
					nextState = stBlockXfer;
				end else begin
					instrSelect = 1'b0;                    // Plain instruction
				end
			end
			stRsrSecond: begin
				kind = kindRsrOperate;
				rsrSecondPass = 1'b1;
				rzCtrl = RzRsrOperate;
				nextState = stIdle;
			end
			stBlSecond: begin
				kind = kindBlBranch;
				nextState = stIdle;
			end
			stBlockXfer: begin
				kind = kindBlockXfer;
				flagHold = 1'b1;
				forwardXfer = 1'b1;                        // Rz advances each transfer
				listStep = 1'b1;
				rzCtrl = RzBlockXfer;
				if (!lastXfer) begin
					uopStall = 1'b1;
				end else if (instr[WriteBackBit]) begin
					uopStall = 1'b1;                       // Base update still to come
					nextState = stBlockWriteback;
				end else begin
					nextState = stIdle;
				end
			end
			stBlockWriteback: begin
				kind = kindBlockWriteback;                 // Rn = Rn +/- 4N
				flagHold = 1'b1;
				nextState = stIdle;
			end
			default: begin
				instrSelect = 1'b0;
				nextState = stIdle;
			end
		endcase
	end

endmodule

`default_nettype wire
